//--- chip_link.f
+incdir+hw
hw/link_pkg.sv
hw/reset_sync.sv
hw/serial_tx.sv
hw/oversampling_rx.sv
hw/rx_word_fifo.sv
hw/chip_link.sv
dv/chip_link_checker.sv
dv/chip_link_tb.sv

//--- Bender.yml
package:
  name: chip_link

sources:
  - include_dirs:
      - hw
    files:
      - hw/link_pkg.sv
      - hw/reset_sync.sv
      - hw/serial_tx.sv
      - hw/oversampling_rx.sv
      - hw/rx_word_fifo.sv
      - hw/chip_link.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/chip_link_checker.sv
      - dv/chip_link_tb.sv

//--- dv/chip_link_tb.sv
`timescale 1ns/10ps
`include "link_macros.svh"

module chip_link_tb;

	import link_pkg::*;

	localparam int LANES = `LINK_LANES;
	localparam int WW = `LINK_WORD_WIDTH;
	localparam int DEPTH = `LINK_FIFO_DEPTH;
	localparam int SYM_CYCLES = (WW + 1) * `LINK_OVERSAMPLE;
	localparam int GAP_CYCLES = (`LINK_IDLE_BITS + 1) * `LINK_OVERSAMPLE;
	localparam int N_SINGLE = 3;
	localparam int N_RAND = 6; // Random frames per lane in each random test
	localparam int MAX_LEN = 6;
	localparam int OVF_WORDS = DEPTH + 4;
	localparam int MAX_WORDS = N_SINGLE + 2 * N_RAND * MAX_LEN + OVF_WORDS;
	// Every word is counted as if it were a frame of its own
	localparam int TIMEOUT_CYCLES = 16 + MAX_WORDS * (SYM_CYCLES + GAP_CYCLES) + 1000;

	logic                   clk;
	logic                   arst_n;
	link_word_t [LANES-1:0] tx_word;
	logic [LANES-1:0]       tx_valid;
	logic [LANES-1:0]       tx_ready;
	logic [LANES-1:0]       serial_out;
	logic [LANES-1:0]       serial_in;
	link_word_t [LANES-1:0] rx_word;
	logic [LANES-1:0]       rx_valid;
	logic [LANES-1:0]       rx_ready;
	logic [LANES-1:0]       rx_overflow;

	link_word_t exp_q [LANES][$]; // Indexed by the lane that receives the word
	int         ready_mode [LANES] = '{default: 0}; // 0 ready, 1 random, 2 held low
	int         n_mismatch = 0;
	int         n_other = 0;
	int         n_checked = 0;

	chip_link u_dut (.*);

	// Two chips facing each other
	assign serial_in = {serial_out[0], serial_out[1]};

	always #5 clk = ~clk;

	task automatic send_word(input int lane, input link_word_t w);
		tx_word[lane]  = w;
		tx_valid[lane] = 1'b1;
		while (!tx_ready[lane])
			@(negedge clk);
		@(negedge clk); // The word was taken on the rising edge just passed
		tx_valid[lane] = 1'b0;
	endtask

	task automatic send_frame(input int lane, input int len);
		link_word_t w;
		for (int k = 0; k < len; k++) begin
			w.data = WW'($urandom);
			w.last = k == len - 1;
			exp_q[1 - lane].push_back(w);
			send_word(lane, w);
		end
	endtask

	task automatic send_random_frames(input int lane);
		repeat (N_RAND)
			send_frame(lane, 1 + int'($urandom % MAX_LEN));
	endtask

	task automatic wait_drained();
		while (exp_q[0].size() != 0 || exp_q[1].size() != 0)
			@(negedge clk);
	endtask

	task automatic check_quiet();
		assert (tx_ready == '0 && serial_out == '0 && rx_valid == '0 && rx_overflow == '0)
		else begin
			n_mismatch++;
			$display("Mismatch at %0t ns: outputs were not all low while the lane reset was held",
				$time);
		end
	endtask

	task automatic report_counts();
		$display("Checked %0d words: %0d mismatches, %0d other failures, %0d assertion failures",
			n_checked, n_mismatch, n_other, u_dut.u_checker.n_fail);
	endtask

	// rx_valid and rx_word are stable here and the handshake lands on the next rising edge
	always @(negedge clk) begin
		link_word_t exp;
		logic       rdy;
		for (int l = 0; l < LANES; l++) begin
			case (ready_mode[l])
				0:       rdy = 1'b1;
				1:       rdy = 1'($urandom);
				default: rdy = 1'b0;
			endcase
			rx_ready[l] = rdy;
			if (rdy && rx_valid[l] && arst_n) begin
				assert (exp_q[l].size() != 0) else begin
					n_other++;
					$display("Lane %0d received a word at %0t ns that was never sent", l, $time);
				end
				if (exp_q[l].size() != 0) begin
					exp = exp_q[l].pop_front();
					n_checked++;
					assert (rx_word[l] == exp) else begin
						n_mismatch++;
						$display("Mismatch at %0t ns: lane %0d got data %h last %b, expected %h %b",
							$time, l, rx_word[l].data, rx_word[l].last, exp.data, exp.last);
					end
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * 10);
		$display("Timeout after %0d cycles while waiting for the link", TIMEOUT_CYCLES);
		report_counts();
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		void'($urandom(17));
		clk      = 1'b0;
		arst_n   = 1'b0;
		tx_word  = '0;
		tx_valid = '0;
		rx_ready = '0;
		repeat (16) begin
			@(negedge clk);
			check_quiet();
		end
		arst_n = 1'b1;
		repeat (`LINK_SYNC_STAGES) begin
			@(negedge clk);
			check_quiet();
		end
		while (tx_ready != '1)
			@(negedge clk);

		// Single-word frames cross in both directions at once
		repeat (N_SINGLE) begin
			fork
				send_frame(0, 1);
				send_frame(1, 1);
			join
		end
		wait_drained();

		for (int mode = 0; mode < 2; mode++) begin
			ready_mode = '{default: mode}; // Second pass toggles rx_ready at random
			fork
				send_random_frames(0);
				send_random_frames(1);
			join
			wait_drained();
			assert (rx_overflow == '0) else begin
				n_mismatch++;
				$display("Mismatch at %0t ns: rx_overflow rose under a load the FIFO can carry",
					$time);
			end
		end

		// Lane 1 stops reading while lane 0 sends more words than its FIFO holds
		ready_mode[1] = 2;
		for (int k = 0; k < OVF_WORDS; k += 4)
			send_frame(0, 4);
		while (!tx_ready[0])
			@(negedge clk);
		while (exp_q[1].size() > DEPTH)
			void'(exp_q[1].pop_back()); // The full FIFO drops the newest words
		assert (rx_overflow[1]) else begin
			n_mismatch++;
			$display("Mismatch at %0t ns: rx_overflow did not rise on lane 1 after the FIFO filled",
				$time);
		end
		ready_mode[1] = 1;
		wait_drained();
		assert (rx_overflow[1]) else begin
			n_mismatch++;
			$display("Mismatch at %0t ns: rx_overflow on lane 1 fell while the FIFO drained",
				$time);
		end

		report_counts();
		if (n_mismatch + n_other + u_dut.u_checker.n_fail == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- dv/chip_link_checker.sv
`timescale 1ns/10ps
`include "link_macros.svh"

module chip_link_checker (
	input logic                                   clk,
	input logic                                   lane_rst_n,
	input link_pkg::link_word_t [`LINK_LANES-1:0] tx_word,
	input logic [`LINK_LANES-1:0]                 tx_valid,
	input logic [`LINK_LANES-1:0]                 tx_ready,
	input logic [`LINK_LANES-1:0]                 serial_out,
	input logic [`LINK_LANES-1:0]                 rx_overflow
);

	int unsigned n_fail = 0;

	for (genvar i = 0; i < `LINK_LANES; i++) begin : g_lane
		// A word that waits for the transmitter must not change under it
		assert property (@(posedge clk) disable iff (!lane_rst_n)
			tx_valid[i] && !tx_ready[i] |=> $stable(tx_word[i]))
		else begin
			n_fail++;
			$error("tx_word changed on lane %0d while it waited for tx_ready", i);
		end

		assert property (@(posedge clk) !lane_rst_n |-> !serial_out[i])
		else begin
			n_fail++;
			$error("serial_out was high on lane %0d during reset", i);
		end

		assert property (@(posedge clk) disable iff (!lane_rst_n)
			rx_overflow[i] |=> rx_overflow[i]) // Sticky until the next reset
		else begin
			n_fail++;
			$error("rx_overflow fell on lane %0d outside reset", i);
		end
	end

endmodule

bind chip_link chip_link_checker u_checker (
	.clk         (clk),
	.lane_rst_n  (lane_rst_n),
	.tx_word     (tx_word),
	.tx_valid    (tx_valid),
	.tx_ready    (tx_ready),
	.serial_out  (serial_out),
	.rx_overflow (rx_overflow)
);

//--- hw/chip_link.sv
`timescale 1ns/10ps
`include "link_macros.svh"

module chip_link (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  link_pkg::link_word_t [`LINK_LANES-1:0] tx_word,
	input  logic [`LINK_LANES-1:0]                  tx_valid,
	output logic [`LINK_LANES-1:0]                  tx_ready,
	output logic [`LINK_LANES-1:0]                  serial_out,
	input  logic [`LINK_LANES-1:0]                  serial_in,
	output link_pkg::link_word_t [`LINK_LANES-1:0] rx_word,
	output logic [`LINK_LANES-1:0]                  rx_valid,
	input  logic [`LINK_LANES-1:0]                  rx_ready,
	output logic [`LINK_LANES-1:0]                  rx_overflow
);

	import link_pkg::*;

	logic lane_rst_n;

	reset_sync u_reset_sync (
		.clk    (clk),
		.arst_n (arst_n),
		.rst_n  (lane_rst_n)
	);

	// Each lane sends on its own wire and receives on its own wire
	for (genvar i = 0; i < `LINK_LANES; i++) begin : g_lane
		logic       rx_push;
		link_word_t rx_push_word;

		serial_tx u_tx (
			.clk        (clk),
			.arst_n     (lane_rst_n),
			.tx_word    (tx_word[i]),
			.tx_valid   (tx_valid[i]),
			.tx_ready   (tx_ready[i]),
			.serial_out (serial_out[i])
		);

		oversampling_rx u_rx (
			.clk          (clk),
			.arst_n       (lane_rst_n),
			.serial_in    (serial_in[i]),
			.rx_push      (rx_push),
			.rx_push_word (rx_push_word)
		);

		// The wire cannot stall so every received word lands here first
		rx_word_fifo u_fifo (
			.clk         (clk),
			.arst_n      (lane_rst_n),
			.push        (rx_push),
			.push_word   (rx_push_word),
			.rx_word     (rx_word[i]),
			.rx_valid    (rx_valid[i]),
			.rx_ready    (rx_ready[i]),
			.rx_overflow (rx_overflow[i])
		);
	end

endmodule

//--- hw/rx_word_fifo.sv
`timescale 1ns/10ps
`include "link_macros.svh"

module rx_word_fifo (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 push,
	input  link_pkg::link_word_t push_word,
	output link_pkg::link_word_t rx_word,
	output logic                 rx_valid,
	input  logic                 rx_ready,
	output logic                 rx_overflow
);

	import link_pkg::*;

	localparam int DEPTH = `LINK_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam logic [PTR_W:0] FULL_CNT = DEPTH[PTR_W:0];

	link_word_t       mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             wr_en;
	logic             rd_en;

	assign full     = count == FULL_CNT;
	assign wr_en    = push && !full;
	assign rx_valid = count != '0;
	assign rd_en    = rx_valid && rx_ready;
	assign rx_word  = mem[rd_ptr]; // Head word is visible without a read request

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= push_word;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			rx_overflow <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (push && full)
				rx_overflow <= 1'b1; // The word is lost and the flag holds until reset
		end
	end

endmodule

//--- hw/oversampling_rx.sv
`timescale 1ns/10ps
`include "link_macros.svh"

module oversampling_rx (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 serial_in,
	output logic                 rx_push,
	output link_pkg::link_word_t rx_push_word
);

	import link_pkg::*;

	localparam int WW = `LINK_WORD_WIDTH;
	localparam int OS = `LINK_OVERSAMPLE;
	localparam int PH_W = $clog2(OS);
	localparam int BIT_W = $clog2(WW + 2);

	localparam logic [PH_W-1:0] MID = PH_W'(OS / 2);
	localparam logic [PH_W-1:0] PH_LAST = PH_W'(OS - 1);
	localparam logic [BIT_W-1:0] SLOT = BIT_W'(WW + 1); // Slot after the last data bit

	rx_state_t        state;
	logic             in_meta;
	logic             in_sync;
	logic             in_prev;
	logic             rise;
	logic             mid;
	logic [PH_W-1:0]  phase;
	logic [BIT_W-1:0] bit_idx;
	logic [WW-1:0]    data_q;

	assign rise = in_sync && !in_prev;
	assign mid  = phase == MID;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			in_meta <= 1'b0;
			in_sync <= 1'b0;
			in_prev <= 1'b0;
		end else begin
			in_meta <= serial_in;
			in_sync <= in_meta;
			in_prev <= in_sync;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= st_hunt;
			phase   <= '0;
			bit_idx <= '0;
			rx_push <= 1'b0;
		end else begin
			rx_push <= 1'b0;
			phase   <= (phase == PH_LAST) ? '0 : phase + 1'b1;

			case (state)
				st_hunt: begin
					if (rise) begin
						state   <= st_data;
						phase   <= PH_W'(1); // The edge cycle itself counts as phase zero
						bit_idx <= '0;
					end
				end
				st_data: begin
					if (bit_idx == SLOT && rise)
						phase <= PH_W'(1); // Realign on the edge of the next marker
					if (mid) begin
						if (bit_idx == '0 && !in_sync) begin
							state <= st_hunt; // Too short for a marker
						end else if (bit_idx == SLOT) begin
							rx_push <= 1'b1;
							if (in_sync)
								bit_idx <= BIT_W'(1);
							else
								state <= st_gap;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				default: begin
					if (phase == PH_LAST)
						state <= st_hunt;
				end
			endcase
		end
	end

	// The marker is shifted in too and falls out over the eight data bits
	always_ff @(posedge clk) begin
		if (state == st_data && mid) begin
			if (bit_idx == SLOT)
				rx_push_word <= link_word_t'{data: data_q, last: !in_sync};
			else
				data_q <= {data_q[WW-2:0], in_sync};
		end
	end

endmodule

//--- hw/serial_tx.sv
`timescale 1ns/10ps
`include "link_macros.svh"

module serial_tx (
	input  logic                 clk,
	input  logic                 arst_n,
	input  link_pkg::link_word_t tx_word,
	input  logic                 tx_valid,
	output logic                 tx_ready,
	output logic                 serial_out
);

	import link_pkg::*;

	localparam int SYM_BITS = `LINK_WORD_WIDTH + 1;
	localparam int OS = `LINK_OVERSAMPLE;
	localparam int PH_W = $clog2(OS);
	localparam int BIT_W = $clog2(SYM_BITS);

	typedef enum logic [1:0] {tx_idle, tx_send, tx_gap} tx_state_t;

	tx_state_t           state;
	logic [PH_W-1:0]     sample_cnt;
	logic [BIT_W-1:0]    bit_cnt;
	logic                cur_last;
	logic                next_full;
	link_word_t          next_word;
	link_word_t          load_word;
	logic [SYM_BITS-1:0] shift_q;
	logic                bit_end;
	logic                last_bit;
	logic                accept;
	logic                load;

	assign bit_end  = sample_cnt == PH_W'(OS - 1);
	assign last_bit = bit_cnt == BIT_W'(SYM_BITS - 1);

	// Inside a frame the next word is taken during the final bit of the current one
	assign tx_ready = (state == tx_idle) ||
		(state == tx_send && last_bit && !cur_last && !next_full);
	assign accept    = tx_valid && tx_ready;
	assign load_word = next_full ? next_word : tx_word;
	assign load      = (state == tx_idle && accept) ||
		(state == tx_send && bit_end && last_bit && (next_full || accept));

	assign serial_out = (state == tx_send) && shift_q[SYM_BITS-1];

	always_ff @(posedge clk) begin
		if (state == tx_send && accept && !load)
			next_word <= tx_word;
		if (load)
			shift_q <= {1'b1, load_word.data}; // Marker goes out first
		else if (bit_end)
			shift_q <= {shift_q[SYM_BITS-2:0], 1'b0};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= tx_gap; // Out of reset the line first serves a full idle gap
			sample_cnt <= '0;
			bit_cnt    <= '0;
			cur_last   <= 1'b0;
			next_full  <= 1'b0;
		end else begin
			if (state != tx_idle)
				sample_cnt <= bit_end ? '0 : sample_cnt + 1'b1;
			if (load)
				next_full <= 1'b0;
			else if (accept && state == tx_send)
				next_full <= 1'b1;

			case (state)
				tx_idle: begin
					if (load) begin
						state      <= tx_send;
						sample_cnt <= '0;
						bit_cnt    <= '0;
						cur_last   <= load_word.last;
					end
				end
				tx_send: begin
					if (bit_end) begin
						if (load) begin
							bit_cnt  <= '0; // Next marker follows without a gap
							cur_last <= load_word.last;
						end else if (last_bit) begin
							state   <= tx_gap;
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				default: begin
					// A zero slot after a word ends the frame and opens the gap
					if (bit_end) begin
						if (bit_cnt == BIT_W'(`LINK_IDLE_BITS - 1)) begin
							state   <= tx_idle;
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule

//--- hw/reset_sync.sv
`timescale 1ns/10ps
`include "link_macros.svh"

module reset_sync (
	input  logic clk,
	input  logic arst_n,
	output logic rst_n
);

	localparam int STAGES = `LINK_SYNC_STAGES;

	logic [STAGES-1:0] sync_q;

	// Assertion is immediate while release walks a one through the chain
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[STAGES-2:0], 1'b1};
		end
	end

	assign rst_n = sync_q[STAGES-1];

endmodule

//--- hw/link_pkg.sv
`include "link_macros.svh"

package link_pkg;

	// One word of a frame together with its end-of-frame flag
	typedef struct packed {
		logic [`LINK_WORD_WIDTH-1:0] data;
		logic                        last;
	} link_word_t;

	typedef enum logic [1:0] {
		st_hunt, // Waiting for the rising edge of a marker
		st_data, // Sampling marker, data bits and the slot after them
		st_gap   // Finishing the zero slot that closed a frame
	} rx_state_t;

endpackage

//--- hw/link_macros.svh
`ifndef LINK_MACROS_SVH
`define LINK_MACROS_SVH

// Data bits per word on the wire
`define LINK_WORD_WIDTH 8

// Clock cycles per bit on the wire
`define LINK_OVERSAMPLE 4

// Zero bits between two frames at least
`define LINK_IDLE_BITS 2

`define LINK_LANES 2 // Independent serial lanes

// Receive FIFO entries per lane and must be a power of two
`define LINK_FIFO_DEPTH 8

`define LINK_SYNC_STAGES 4 // Flip-flops in the reset release chain

`endif
